// File: alu_pkg.sv
// shared ALU definitions; opcode and condition encodings are private to this design and not the reference ISA
package alu_pkg;

  localparam int data_w = 64;
  localparam int flags_w = 6;
  localparam int n_sizes = 4;
  localparam int op_w = 12;

  localparam int size_bits [n_sizes] = '{8, 16, 32, 64}; // indexed by size code
  localparam logic [data_w-1:0] size_mask [n_sizes] = '{
    64'h0000_0000_0000_00ff,
    64'h0000_0000_0000_ffff,
    64'h0000_0000_ffff_ffff,
    64'hffff_ffff_ffff_ffff
  };

  // flag word is {C,O,A,S,Z,P}
  localparam int flag_c = 5;
  localparam int flag_o = 4;
  localparam int flag_a = 3;
  localparam int flag_s = 2;
  localparam int flag_z = 1;
  localparam int flag_p = 0;

  localparam logic [4:0] op_add  = 5'd0;
  localparam logic [4:0] op_sub  = 5'd1;
  localparam logic [4:0] op_and  = 5'd4;
  localparam logic [4:0] op_or   = 5'd5;
  localparam logic [4:0] op_xor  = 5'd6;
  localparam logic [4:0] op_nxor = 5'd7;
  localparam logic [4:0] op_mov  = 5'd8;
  localparam logic [4:0] op_zxt  = 5'd9;
  localparam logic [4:0] op_sxt  = 5'd10;
  localparam logic [4:0] op_cmov = 5'd12; // b when taken, else a
  localparam logic [4:0] op_cset = 5'd13;

  localparam logic [3:0] cc_z   = 4'd0;
  localparam logic [3:0] cc_nz  = 4'd1;
  localparam logic [3:0] cc_s   = 4'd2;
  localparam logic [3:0] cc_ns  = 4'd3;
  localparam logic [3:0] cc_ugt = 4'd4;
  localparam logic [3:0] cc_ule = 4'd5;
  localparam logic [3:0] cc_uge = 4'd6;
  localparam logic [3:0] cc_ult = 4'd7;
  localparam logic [3:0] cc_sgt = 4'd8;
  localparam logic [3:0] cc_sle = 4'd9;
  localparam logic [3:0] cc_sge = 4'd10;
  localparam logic [3:0] cc_slt = 4'd11;
  localparam logic [3:0] cc_o   = 4'd12;
  localparam logic [3:0] cc_no  = 4'd13;
  localparam logic [3:0] cc_p   = 4'd14;
  localparam logic [3:0] cc_np  = 4'd15;

  typedef struct packed {
    logic       no_flags;
    logic [1:0] ext_from; // source size for zxt and sxt
    logic [1:0] spare;
    logic [1:0] size;
    logic [4:0] opcode;
  } alu_plain_t;

  typedef struct packed {
    logic       no_flags;
    logic [3:0] cc; // overlays ext_from and spare
    logic [1:0] size;
    logic [4:0] opcode;
  } alu_cond_t;

  typedef union packed {
    alu_plain_t plain;
    alu_cond_t  cond;
  } alu_op_u;

endpackage

// File: alu_stage_if.sv
// stage-one bundle between issue and the flag lanes; payload is only meaningful while st_valid is high
`timescale 1ns/10ps

interface alu_stage_if import alu_pkg::*; ();

  logic                st_valid;
  alu_op_u             st_op;
  logic [data_w-1:0]   st_res;      // already masked to size
  logic [n_sizes-1:0]  st_carry;    // out of bits 7, 15, 31, 63
  logic                st_carry4;
  logic [n_sizes-1:0]  st_a_sign;
  logic [n_sizes-1:0]  st_b_sign;
  logic [flags_w-1:0]  st_flags_in;

  modport issue (output st_valid, st_op, st_res, st_carry, st_carry4, st_a_sign, st_b_sign,
                 st_flags_in);
  modport lane (input st_op, st_res, st_carry, st_a_sign, st_b_sign);
  modport drain (input st_valid, st_op, st_res, st_carry4, st_flags_in);

endinterface

// File: cond_eval.sv
// condition evaluator; C is taken as the raw adder carry, so uge is C set and ult is C clear
`timescale 1ns/10ps

module cond_eval import alu_pkg::*; (
  input  logic [flags_w-1:0] flags,
  input  logic [3:0]         cc,
  output logic               taken
);

  logic c, o, s, z, p;
  logic slt; // signed less than

  assign c = flags[flag_c];
  assign o = flags[flag_o];
  assign s = flags[flag_s];
  assign z = flags[flag_z];
  assign p = flags[flag_p];
  assign slt = s ^ o;

  always_comb begin
    case (cc)
      cc_z:    taken = z;
      cc_nz:   taken = ~z;
      cc_s:    taken = s;
      cc_ns:   taken = ~s;
      cc_ugt:  taken = c & ~z;
      cc_ule:  taken = ~c | z;
      cc_uge:  taken = c;
      cc_ult:  taken = ~c;
      cc_sgt:  taken = ~(slt | z);
      cc_sle:  taken = slt | z;
      cc_sge:  taken = ~slt;
      cc_slt:  taken = slt;
      cc_o:    taken = o;
      cc_no:   taken = ~o;
      cc_p:    taken = p;
      cc_np:   taken = ~p;
      default: taken = 1'b0;
    endcase
  end

endmodule

// File: alu_issue.sv
// issue stage; sub is a + ~b + 1 so its carries are inverted borrows, and operand b is the mov/extend source
`timescale 1ns/10ps

module alu_issue import alu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  alu_op_u            op,
  input  logic [data_w-1:0]  a,
  input  logic [data_w-1:0]  b,
  input  logic [flags_w-1:0] flags_in,
  alu_stage_if.issue         st
);

  logic              is_sub;
  logic [data_w-1:0] b_eff;
  logic [data_w:0]   sum;
  logic [data_w:0]   carry_in; // carry into each bit, bit 64 is the final carry
  logic              taken;
  logic [data_w-1:0] zxt_val;
  logic [data_w-1:0] sxt_val;
  logic [data_w-1:0] res_raw;

  assign is_sub = (op.plain.opcode == op_sub);
  assign b_eff = is_sub ? ~b : b;
  assign sum = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, is_sub};
  assign carry_in = sum ^ {1'b0, a} ^ {1'b0, b_eff};

  cond_eval i_cond (
    .flags (flags_in),
    .cc    (op.cond.cc),
    .taken (taken)
  );

  assign zxt_val = b & size_mask[op.plain.ext_from];

  always_comb begin
    case (op.plain.ext_from)
      2'd0:    sxt_val = {{56{b[7]}}, b[7:0]};
      2'd1:    sxt_val = {{48{b[15]}}, b[15:0]};
      2'd2:    sxt_val = {{32{b[31]}}, b[31:0]};
      default: sxt_val = b;
    endcase
  end

  always_comb begin
    case (op.plain.opcode)
      op_add,
      op_sub:  res_raw = sum[data_w-1:0];
      op_and:  res_raw = a & b;
      op_or:   res_raw = a | b;
      op_xor:  res_raw = a ^ b;
      op_nxor: res_raw = ~(a ^ b);
      op_mov:  res_raw = b;
      op_zxt:  res_raw = zxt_val;
      op_sxt:  res_raw = sxt_val;
      op_cmov: res_raw = taken ? b : a;
      op_cset: res_raw = {{(data_w-1){1'b0}}, taken};
      default: res_raw = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      st.st_valid <= 1'b0;
    end else begin
      st.st_valid <= in_valid;
    end
  end

  // payload only moves with a valid op
  always_ff @(posedge clk) begin
    if (in_valid) begin
      st.st_op <= op;
      st.st_res <= res_raw & size_mask[op.plain.size];
      st.st_carry4 <= carry_in[4];
      st.st_flags_in <= flags_in;
      for (int i = 0; i < n_sizes; i++) begin
        st.st_carry[i] <= carry_in[size_bits[i]];
        st.st_a_sign[i] <= a[size_bits[i]-1];
        st.st_b_sign[i] <= b[size_bits[i]-1];
      end
    end
  end

endmodule

// File: width_flags.sv
// one flag lane per operand size; lane must be below n_sizes, and O is only meaningful for add and sub
`timescale 1ns/10ps

module width_flags import alu_pkg::*; #(
  parameter int lane = 0
) (
  alu_stage_if.lane st,
  output logic      z,
  output logic      s,
  output logic      c,
  output logic      o
);

  localparam int w = size_bits[lane];

  logic is_sub;
  logic a_s, b_s, r_s;

  assign is_sub = (st.st_op.plain.opcode == op_sub);
  assign a_s = st.st_a_sign[lane];
  assign b_s = st.st_b_sign[lane];
  assign r_s = st.st_res[w-1];

  assign z = ~|st.st_res[w-1:0];
  assign s = r_s;
  assign c = st.st_carry[lane];

  // result sign flips against a; add needs like signs, sub needs unlike signs
  assign o = (r_s ^ a_s) & (is_sub ? (a_s ^ b_s) : ~(a_s ^ b_s));

endmodule

// File: flag_select.sv
// flag select and output stage; result and flags_out change only on a valid op and hold otherwise
`timescale 1ns/10ps

module flag_select import alu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  alu_stage_if.drain         st,
  input  logic [n_sizes-1:0] lane_z,
  input  logic [n_sizes-1:0] lane_s,
  input  logic [n_sizes-1:0] lane_c,
  input  logic [n_sizes-1:0] lane_o,
  output logic               out_valid,
  output logic [data_w-1:0]  result,
  output logic [flags_w-1:0] flags_out,
  output logic               flags_we
);

  logic [1:0]         sz;
  logic               is_arith;
  logic               is_logic;
  logic               we;
  logic [flags_w-1:0] flags_calc;
  logic [flags_w-1:0] flags_next;

  assign sz = st.st_op.plain.size;
  assign is_arith = st.st_op.plain.opcode inside {op_add, op_sub};
  assign is_logic = st.st_op.plain.opcode inside {op_and, op_or, op_xor, op_nxor};
  assign we = (is_arith | is_logic) & ~st.st_op.plain.no_flags;

  always_comb begin
    flags_calc = '0; // C, O, A stay clear for logic ops
    flags_calc[flag_s] = lane_s[sz];
    flags_calc[flag_z] = lane_z[sz];
    flags_calc[flag_p] = ~^st.st_res[7:0]; // even parity of low byte
    if (is_arith) begin
      flags_calc[flag_c] = lane_c[sz];
      flags_calc[flag_o] = lane_o[sz];
      flags_calc[flag_a] = st.st_carry4;
    end
  end

  assign flags_next = we ? flags_calc : st.st_flags_in;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      flags_we <= 1'b0;
      result <= '0;
      flags_out <= '0;
    end else begin
      out_valid <= st.st_valid;
      flags_we <= st.st_valid & we;
      if (st.st_valid) begin
        result <= st.st_res;
        flags_out <= flags_next;
      end
    end
  end

endmodule

// File: alu_top.sv
// two-stage ALU top; in_valid at edge N gives out_valid at N+2 with no back-pressure
`timescale 1ns/10ps

module alu_top import alu_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  logic [op_w-1:0]    op,
  input  logic [data_w-1:0]  a,
  input  logic [data_w-1:0]  b,
  input  logic [flags_w-1:0] flags_in,
  output logic               out_valid,
  output logic [data_w-1:0]  result,
  output logic [flags_w-1:0] flags_out,
  output logic               flags_we
);

  alu_stage_if st_if ();

  logic [n_sizes-1:0] lane_z;
  logic [n_sizes-1:0] lane_s;
  logic [n_sizes-1:0] lane_c;
  logic [n_sizes-1:0] lane_o;

  alu_issue i_issue (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .op       (alu_op_u'(op)),
    .a        (a),
    .b        (b),
    .flags_in (flags_in),
    .st       (st_if.issue)
  );

  for (genvar i = 0; i < n_sizes; i++) begin : g_lane
    width_flags #(.lane(i)) i_lane (
      .st (st_if.lane),
      .z  (lane_z[i]),
      .s  (lane_s[i]),
      .c  (lane_c[i]),
      .o  (lane_o[i])
    );
  end

  flag_select i_flag_select (
    .clk       (clk),
    .rst       (rst),
    .st        (st_if.drain),
    .lane_z    (lane_z),
    .lane_s    (lane_s),
    .lane_c    (lane_c),
    .lane_o    (lane_o),
    .out_valid (out_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

endmodule

// File: alu_properties.sv
// timing checks bound into alu_top; assumes in_valid stays low while rst is high
`timescale 1ns/10ps

module alu_properties (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic out_valid,
  input logic flags_we
);

  // fixed two-cycle latency, no stalls
  latency_two: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 2))
    else $error("out_valid does not follow in_valid by two cycles");

  we_needs_valid: assert property (@(posedge clk) flags_we |-> out_valid)
    else $error("flags_we high without out_valid");

  quiet_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule

bind alu_top alu_properties i_alu_properties (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .flags_we  (flags_we)
);

// File: tb_alu.sv
// testbench for alu_top; run from the project root so that alu_trace.txt is found
`timescale 1ns/10ps

module tb_alu import alu_pkg::*; ();

  localparam int max_lines = 128;

  logic               clk;
  logic               rst;
  logic               in_valid;
  logic [op_w-1:0]    op;
  logic [data_w-1:0]  a;
  logic [data_w-1:0]  b;
  logic [flags_w-1:0] flags_in;
  logic               out_valid;
  logic [data_w-1:0]  result;
  logic [flags_w-1:0] flags_out;
  logic               flags_we;

  // one entry per trace line
  int                 t_test [max_lines];
  int                 t_gap [max_lines];
  logic [op_w-1:0]    t_op [max_lines];
  logic [data_w-1:0]  t_a [max_lines];
  logic [data_w-1:0]  t_b [max_lines];
  logic [flags_w-1:0] t_fin [max_lines];
  logic [data_w-1:0]  t_res [max_lines];
  logic [flags_w-1:0] t_flags [max_lines];
  logic               t_we [max_lines];
  bit                 t_last [max_lines];

  int n_lines = 0;
  int total_gap = 0;
  int pend_idx [$]; // trace index of each op in flight
  int pend_due [$]; // cycle its result is due
  int cycle = 0;
  int limit = 1000;
  int errors = 0;
  int errors_before = 0;
  int checks = 0;
  int tests = 0;

  alu_top i_alu_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .flags_in  (flags_in),
    .out_valid (out_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    while (cycle <= limit) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout after %0d cycles with results still outstanding", cycle);
    $display("Test failed");
    $finish;
  end

  task automatic read_trace(output bit ok);
    int fd;
    int code;
    int tn;
    int gp;
    string line;
    logic [op_w-1:0]    o;
    logic [data_w-1:0]  av;
    logic [data_w-1:0]  bv;
    logic [data_w-1:0]  rv;
    logic [flags_w-1:0] fv;
    logic [flags_w-1:0] ev;
    logic               wv;
    fd = $fopen("alu_trace.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%d %d %h %h %h %h %h %h %h",
                         tn, gp, o, av, bv, fv, rv, ev, wv);
          if (code != 9 || n_lines == max_lines) begin
            $display("trace line could not be used: %s", line);
            errors++;
          end else begin
            t_test[n_lines] = tn;
            t_gap[n_lines] = gp;
            t_op[n_lines] = o;
            t_a[n_lines] = av;
            t_b[n_lines] = bv;
            t_fin[n_lines] = fv;
            t_res[n_lines] = rv;
            t_flags[n_lines] = ev;
            t_we[n_lines] = wv;
            total_gap += gp;
            n_lines++;
          end
        end
      end
      $fclose(fd);
      for (int i = 0; i < n_lines; i++) begin
        if (i == n_lines - 1) t_last[i] = 1'b1;
        else t_last[i] = (t_test[i+1] != t_test[i]);
      end
      ok = (n_lines > 0);
    end
  endtask

  function automatic void report_test(int num);
    int e;
    e = errors - errors_before;
    tests++;
    if (e == 0) $display("test %0d done, ok", num);
    else $display("test %0d done, %0d errors", num, e);
    errors_before = errors;
  endfunction

  task automatic check_outputs();
    int k;
    if (pend_idx.size() > 0 && pend_due[0] == cycle) begin
      k = pend_idx.pop_front();
      void'(pend_due.pop_front());
      checks++;
      assert (out_valid === 1'b1) else begin
        $display("Error: out_valid got %h expected 1", out_valid);
        errors++;
      end
      assert (result === t_res[k]) else begin
        $display("Error: result got %h expected %h", result, t_res[k]);
        errors++;
      end
      assert (flags_out === t_flags[k]) else begin
        $display("Error: flags_out got %h expected %h", flags_out, t_flags[k]);
        errors++;
      end
      assert (flags_we === t_we[k]) else begin
        $display("Error: flags_we got %h expected %h", flags_we, t_we[k]);
        errors++;
      end
      if (t_last[k]) report_test(t_test[k]);
    end else begin
      // nothing due this cycle
      assert (out_valid === 1'b0) else begin
        $display("Error: out_valid got %h expected 0", out_valid);
        errors++;
      end
      assert (flags_we === 1'b0) else begin
        $display("Error: flags_we got %h expected 0", flags_we);
        errors++;
      end
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    check_outputs();
  endtask

  initial begin
    bit trace_ok;
    rst = 1'b1;
    in_valid = 1'b0;
    op = '0;
    a = '0;
    b = '0;
    flags_in = '0;
    read_trace(trace_ok);
    if (!trace_ok) begin
      $display("alu_trace.txt could not be opened or holds no operations");
      $display("Test failed");
      $finish;
    end else begin
      limit = 2 * (n_lines + total_gap) + 20;
      errors_before = errors;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_outputs();
      for (int i = 0; i < n_lines; i++) begin
        in_valid = 1'b0;
        repeat (t_gap[i]) next_cycle();
        op = t_op[i];
        a = t_a[i];
        b = t_b[i];
        flags_in = t_fin[i];
        in_valid = 1'b1;
        pend_idx.push_back(i);
        pend_due.push_back(cycle + 2);
        next_cycle();
      end
      in_valid = 1'b0;
      while (pend_idx.size() > 0) next_cycle();
      repeat (2) next_cycle(); // outputs must stay quiet
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

// File: alu_trace.txt
# test gap op a b flags_in result flags_out flags_we
# all hex except test and gap; gap is idle cycles before the op
1 3 000 abcdef00000000ff 0000000000000001 00 0000000000000000 2b 1
1 0 000 000000000000007f 0000000000000001 00 0000000000000080 1c 1
1 1 001 0000000000000005 0000000000000007 00 00000000000000fe 04 1
1 0 001 0000000000000080 0000000000000001 00 000000000000007f 30 1
1 0 020 0000000000008000 0000000000008000 00 0000000000000000 33 1
1 2 021 0000000000001234 0000000000001234 00 0000000000000000 2b 1
1 0 040 000000007fffffff 0000000000000001 00 0000000080000000 1d 1
1 0 041 0000000000000000 0000000000000001 00 00000000ffffffff 05 1
1 0 060 ffffffffffffffff 0000000000000002 00 0000000000000001 28 1
1 1 061 8000000000000000 0000000000000001 3f 7fffffffffffffff 31 1
2 0 044 ffff0000f0f0f0f0 12345678ff00ff00 38 00000000f000f000 05 1
2 1 065 0000000000000000 0000000000000000 3c 0000000000000000 03 1
2 0 046 aaaaaaaa12345601 5555555512345600 20 0000000000000001 00 1
2 0 067 0000000000000003 0000000000000000 00 fffffffffffffffc 05 1
3 0 068 1111111111111111 8877665544332211 2a 8877665544332211 2a 0
3 0 069 0000000000000000 8877665544332281 15 0000000000000081 15 0
3 0 269 0000000000000000 8877665544332281 00 0000000000002281 00 0
3 1 469 0000000000000000 8877665544332281 3f 0000000044332281 3f 0
3 0 06a 0000000000000000 8877665544332281 01 ffffffffffffff81 01 0
3 0 26a 0000000000000000 8877665544337f81 02 0000000000007f81 02 0
3 0 46a 0000000000000000 8877665594332281 04 ffffffff94332281 04 0
3 0 66a 0000000000000000 8877665544332281 08 8877665544332281 08 0
4 0 06d 0000000000000000 0000000000000000 02 0000000000000001 02 0
4 0 06c 0123456789abcdef fedcba9876543210 00 0123456789abcdef 00 0
4 0 0ec 0123456789abcdef fedcba9876543210 00 fedcba9876543210 00 0
4 0 0ed 0000000000000000 0000000000000000 02 0000000000000000 02 0
4 0 16d 0000000000000000 0000000000000000 04 0000000000000001 04 0
4 0 16c 0123456789abcdef fedcba9876543210 00 0123456789abcdef 00 0
4 0 1ec 0123456789abcdef fedcba9876543210 00 fedcba9876543210 00 0
4 0 1ed 0000000000000000 0000000000000000 04 0000000000000000 04 0
4 0 26d 0000000000000000 0000000000000000 20 0000000000000001 20 0
4 0 26c 0123456789abcdef fedcba9876543210 22 0123456789abcdef 22 0
4 0 2ec 0123456789abcdef fedcba9876543210 22 fedcba9876543210 22 0
4 0 2ed 0000000000000000 0000000000000000 20 0000000000000000 20 0
4 0 36d 0000000000000000 0000000000000000 20 0000000000000001 20 0
4 0 36c 0123456789abcdef fedcba9876543210 00 0123456789abcdef 00 0
4 0 3ec 0123456789abcdef fedcba9876543210 00 fedcba9876543210 00 0
4 0 3ed 0000000000000000 0000000000000000 20 0000000000000000 20 0
4 2 46d 0000000000000000 0000000000000000 14 0000000000000001 14 0
4 0 46c 0123456789abcdef fedcba9876543210 04 0123456789abcdef 04 0
4 0 4ec 0123456789abcdef fedcba9876543210 10 fedcba9876543210 10 0
4 0 4ed 0000000000000000 0000000000000000 00 0000000000000000 00 0
4 0 56d 0000000000000000 0000000000000000 14 0000000000000001 14 0
4 0 56c 0123456789abcdef fedcba9876543210 10 0123456789abcdef 10 0
4 0 5ec 0123456789abcdef fedcba9876543210 04 fedcba9876543210 04 0
4 0 5ed 0000000000000000 0000000000000000 14 0000000000000000 14 0
4 0 66d 0000000000000000 0000000000000000 10 0000000000000001 10 0
4 0 66c 0123456789abcdef fedcba9876543210 00 0123456789abcdef 00 0
4 0 6ec 0123456789abcdef fedcba9876543210 00 fedcba9876543210 00 0
4 0 6ed 0000000000000000 0000000000000000 10 0000000000000000 10 0
4 0 76d 0000000000000000 0000000000000000 01 0000000000000001 01 0
4 0 76c 0123456789abcdef fedcba9876543210 00 0123456789abcdef 00 0
4 0 7ec 0123456789abcdef fedcba9876543210 00 fedcba9876543210 00 0
4 0 7ed 0000000000000000 0000000000000000 01 0000000000000000 01 0
5 0 860 0000000000000010 0000000000000020 15 0000000000000030 15 0
5 0 060 0000000000000010 0000000000000020 15 0000000000000030 01 1
5 4 000 0000000000000001 0000000000000001 00 0000000000000002 00 1

// File: tb.f
alu_pkg.sv
alu_stage_if.sv
cond_eval.sv
alu_issue.sv
width_flags.sv
flag_select.sv
alu_top.sv
alu_properties.sv
tb_alu.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_alu -f tb.f -o Vtb_alu

sim_out=$(./obj_dir/Vtb_alu || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
